// ==== hdl/vrf_settings.svh ====
`ifndef VRF_SETTINGS_SVH
`define VRF_SETTINGS_SVH

// one bank per write port
`define VRF_W_PORTS 2

// every bank keeps a private replica per read port
`define VRF_R_PORTS 3

// words per RAM and bits per word
`define VRF_DEPTH 32
`define VRF_WIDTH 32

// address bits follow the depth
`define VRF_AW $clog2(`VRF_DEPTH)

`endif

// ==== hdl/vrf_pkg.sv ====
`include "vrf_settings.svh"

package vrf_pkg;

   // one write port request, one enable bit per byte
   typedef struct packed {
      logic                      wen;
      logic [`VRF_AW-1:0]        waddr;
      logic [`VRF_WIDTH/8-1:0]   bwe;
      logic [`VRF_WIDTH-1:0]     wdata;
   } vrf_wreq_t;

   // one read port request
   typedef struct packed {
      logic                      ren;
      logic [`VRF_AW-1:0]        raddr;
   } vrf_rreq_t;

   // one read response, valid for a single cycle
   typedef struct packed {
      logic                      rvalid;
      logic [`VRF_WIDTH-1:0]     rdata;
   } vrf_rresp_t;

   // encoded write into one bank
   // wdata already holds the XOR with the other banks
   typedef struct packed {
      logic                      wen;
      logic [`VRF_AW-1:0]        waddr;
      logic [`VRF_WIDTH/8-1:0]   bwe;
      logic [`VRF_WIDTH-1:0]     wdata;
   } vrf_bank_wr_t;

endpackage

// ==== hdl/sdp_bwe_bram.sv ====
`timescale 1ns/1ps
`include "vrf_settings.svh"

module sdp_bwe_bram
   import vrf_pkg::*;
(
   input  logic                  clk,
   input  vrf_bank_wr_t          wr_i,
   input  logic [`VRF_AW-1:0]    raddr_i,
   input  logic                  ren_i,
   output logic [`VRF_WIDTH-1:0] rdata_o
);

   logic [`VRF_WIDTH-1:0] mem [`VRF_DEPTH];

   // write port, byte lanes enabled one by one
   always_ff @(posedge clk)
   begin
      if (wr_i.wen)
      begin
         for (int i = 0; i < `VRF_WIDTH/8; i++)
         begin
            if (wr_i.bwe[i])
            begin
               mem[wr_i.waddr][i*8 +: 8] <= wr_i.wdata[i*8 +: 8];
            end
         end
      end
   end

   // read port
   // read-before-write on a same-cycle address match
   always_ff @(posedge clk)
   begin
      if (ren_i)
      begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

// ==== hdl/vrf_write_encoder.sv ====
`timescale 1ns/1ps
`include "vrf_settings.svh"

module vrf_write_encoder
   import vrf_pkg::*;
(
   input  logic                                clk,
   input  logic                                rstn,
   input  vrf_wreq_t    [`VRF_W_PORTS-1:0]     wreq_i,
   output vrf_bank_wr_t [`VRF_W_PORTS-1:0]     bank_wr_o
);

   // requests sampled at the last edge
   vrf_wreq_t    [`VRF_W_PORTS-1:0] wreq_q;

   // the bank writes that landed at the last edge
   vrf_bank_wr_t [`VRF_W_PORTS-1:0] bank_wr_q;

   // contents of every other bank at the write address, per bank
   logic [`VRF_W_PORTS-1:0][`VRF_W_PORTS-2:0][`VRF_WIDTH-1:0] enc_rdata;
   logic [`VRF_W_PORTS-1:0][`VRF_W_PORTS-2:0][`VRF_WIDTH-1:0] other_word;

   // write enables cleared on reset
   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         for (int b = 0; b < `VRF_W_PORTS; b++)
         begin
            wreq_q[b].wen    <= 1'b0;
            bank_wr_q[b].wen <= 1'b0;
         end
      end
      else
      begin
         wreq_q    <= wreq_i;
         bank_wr_q <= bank_wr_o;
      end
   end

   for (genvar b = 0; b < `VRF_W_PORTS; b++)
   begin : g_bank
      for (genvar k = 0; k < `VRF_W_PORTS-1; k++)
      begin : g_copy
         // index of the other bank mirrored by this copy
         localparam int ob = (k < b) ? k : k + 1;

         logic fwd_hit;

         // private copy of bank ob read with the raw request address
         sdp_bwe_bram u_enc_ram (
            .clk     (clk),
            .wr_i    (bank_wr_o[ob]),
            .raddr_i (wreq_i[b].waddr),
            .ren_i   (wreq_i[b].wen),
            .rdata_o (enc_rdata[b][k])
         );

         // the RAM read raced with a write to the same address,
         // so its output is stale for the bytes that write touched
         assign fwd_hit = bank_wr_q[ob].wen &&
                          (bank_wr_q[ob].waddr == wreq_q[b].waddr);

         for (genvar i = 0; i < `VRF_WIDTH/8; i++)
         begin : g_byte
            assign other_word[b][k][i*8 +: 8] =
               (fwd_hit && bank_wr_q[ob].bwe[i]) ? bank_wr_q[ob].wdata[i*8 +: 8]
                                                  : enc_rdata[b][k][i*8 +: 8];
         end
      end
   end

   // encode: new data XOR current contents of all other banks
   always_comb
   begin
      logic [`VRF_WIDTH-1:0] enc;

      for (int b = 0; b < `VRF_W_PORTS; b++)
      begin
         enc = wreq_q[b].wdata;
         for (int k = 0; k < `VRF_W_PORTS-1; k++)
         begin
            enc = enc ^ other_word[b][k];
         end
         bank_wr_o[b].wen   = wreq_q[b].wen;
         bank_wr_o[b].waddr = wreq_q[b].waddr;
         bank_wr_o[b].bwe   = wreq_q[b].bwe;
         bank_wr_o[b].wdata = enc;
      end
   end

   // two ports must never write the same byte of one address together,
   // otherwise the XOR of the banks no longer gives either value
   for (genvar i = 0; i < `VRF_W_PORTS; i++)
   begin : g_chk_i
      for (genvar j = i + 1; j < `VRF_W_PORTS; j++)
      begin : g_chk_j
         a_no_byte_overlap : assert property (
            @(posedge clk) disable iff (!rstn)
            !(wreq_i[i].wen && wreq_i[j].wen &&
              (wreq_i[i].waddr == wreq_i[j].waddr) &&
              |(wreq_i[i].bwe & wreq_i[j].bwe))
         );
      end
   end

endmodule

// ==== hdl/vrf_read_bank.sv ====
`timescale 1ns/1ps
`include "vrf_settings.svh"

module vrf_read_bank
   import vrf_pkg::*;
(
   input  logic                                     clk,
   input  vrf_bank_wr_t                             bank_wr_i,
   input  vrf_rreq_t [`VRF_R_PORTS-1:0]             rreq_i,
   output logic [`VRF_R_PORTS-1:0][`VRF_WIDTH-1:0]  rdata_o
);

   // one replica per read port
   // all replicas take the same encoded write, so they stay identical
   for (genvar r = 0; r < `VRF_R_PORTS; r++)
   begin : g_replica
      sdp_bwe_bram u_read_ram (
         .clk     (clk),
         .wr_i    (bank_wr_i),
         .raddr_i (rreq_i[r].raddr),
         .ren_i   (rreq_i[r].ren),
         .rdata_o (rdata_o[r])
      );
   end

endmodule

// ==== hdl/vrf_read_combiner.sv ====
`timescale 1ns/1ps
`include "vrf_settings.svh"

module vrf_read_combiner
   import vrf_pkg::*;
(
   input  logic                                                    clk,
   input  logic                                                    rstn,
   input  vrf_rreq_t [`VRF_R_PORTS-1:0]                            rreq_i,
   input  logic [`VRF_W_PORTS-1:0][`VRF_R_PORTS-1:0][`VRF_WIDTH-1:0] bank_rdata_i,
   output vrf_rresp_t [`VRF_R_PORTS-1:0]                           rresp_o
);

   // ren aligned with the RAM output
   logic [`VRF_R_PORTS-1:0] ren_q;

   // decoded word per read port
   logic [`VRF_R_PORTS-1:0][`VRF_WIDTH-1:0] xor_word;

   always_comb
   begin
      for (int r = 0; r < `VRF_R_PORTS; r++)
      begin
         xor_word[r] = '0;
         for (int b = 0; b < `VRF_W_PORTS; b++)
         begin
            xor_word[r] = xor_word[r] ^ bank_rdata_i[b][r];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         ren_q <= '0;
         for (int r = 0; r < `VRF_R_PORTS; r++)
         begin
            rresp_o[r].rvalid <= 1'b0;
         end
      end
      else
      begin
         for (int r = 0; r < `VRF_R_PORTS; r++)
         begin
            ren_q[r]          <= rreq_i[r].ren;
            rresp_o[r].rvalid <= ren_q[r];
            if (ren_q[r])
            begin
               rresp_o[r].rdata <= xor_word[r];
            end
         end
      end
   end

   // a valid response must come from written locations in every bank
   for (genvar r = 0; r < `VRF_R_PORTS; r++)
   begin : g_chk
      a_rdata_known : assert property (
         @(posedge clk) disable iff (!rstn)
         rresp_o[r].rvalid |-> !$isunknown(rresp_o[r].rdata)
      );
   end

endmodule

// ==== hdl/vrf_top.sv ====
`timescale 1ns/1ps
`include "vrf_settings.svh"

module vrf_top
   import vrf_pkg::*;
(
   input  logic                              clk,
   input  logic                              rstn,
   input  vrf_wreq_t  [`VRF_W_PORTS-1:0]     wreq_i,
   input  vrf_rreq_t  [`VRF_R_PORTS-1:0]     rreq_i,
   output vrf_rresp_t [`VRF_R_PORTS-1:0]     rresp_o
);

   // encoded write per bank
   vrf_bank_wr_t [`VRF_W_PORTS-1:0] bank_wr;

   // raw replica outputs, per bank and per read port
   logic [`VRF_W_PORTS-1:0][`VRF_R_PORTS-1:0][`VRF_WIDTH-1:0] bank_rdata;

   vrf_write_encoder u_write_encoder (
      .clk       (clk),
      .rstn      (rstn),
      .wreq_i    (wreq_i),
      .bank_wr_o (bank_wr)
   );

   // banks work side by side, one per write port
   for (genvar b = 0; b < `VRF_W_PORTS; b++)
   begin : g_bank
      vrf_read_bank u_read_bank (
         .clk       (clk),
         .bank_wr_i (bank_wr[b]),
         .rreq_i    (rreq_i),
         .rdata_o   (bank_rdata[b])
      );
   end

   vrf_read_combiner u_read_combiner (
      .clk          (clk),
      .rstn         (rstn),
      .rreq_i       (rreq_i),
      .bank_rdata_i (bank_rdata),
      .rresp_o      (rresp_o)
   );

endmodule

// ==== testbench/vrf_tb.sv ====
`timescale 1ns/1ps
`include "vrf_settings.svh"

module vrf_tb
   import vrf_pkg::*;
();

   localparam int W            = `VRF_W_PORTS;
   localparam int R            = `VRF_R_PORTS;
   localparam int DEPTH        = `VRF_DEPTH;
   localparam int WIDTH        = `VRF_WIDTH;
   localparam int AW           = `VRF_AW;
   localparam int NBYTES       = `VRF_WIDTH/8;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 10;
   localparam int IDLE_STEPS   = 5;
   localparam int FILL_STEPS   = DEPTH/2;
   localparam int TABLE_ROWS   = 28;
   localparam int RAND_COUNT   = 400;
   localparam int DRAIN_STEPS  = 3;
   localparam int RUN_CYCLES   = RESET_CYCLES + IDLE_STEPS + FILL_STEPS + TABLE_ROWS +
                                 RAND_COUNT + DRAIN_STEPS + 20;

   // expected responses for the reads of one cycle
   typedef struct packed {
      logic [R-1:0]            valid;
      logic [R-1:0][WIDTH-1:0] data;
   } exp_t;

   // stimulus row whose data only counts where fixed is set
   typedef struct packed {
      vrf_wreq_t [W-1:0]       wr;
      vrf_rreq_t [R-1:0]       rd;
      logic [R-1:0]            fixed;
      logic [R-1:0][WIDTH-1:0] data;
   } row_t;

   logic               clk = 1'b0;
   logic               rstn;
   vrf_wreq_t  [W-1:0] wreq;
   vrf_rreq_t  [R-1:0] rreq;
   vrf_rresp_t [R-1:0] rresp;

   // reference memory that catches up with the driven writes two cycles late
   logic [WIDTH-1:0]  model_mem [DEPTH];
   vrf_wreq_t [W-1:0] wr_hist1;
   vrf_wreq_t [W-1:0] wr_hist2;

   // expected responses of the last two cycles
   exp_t exp_p1;
   exp_t exp_p2;

   row_t table_rows [TABLE_ROWS];
   int   row_count;
   int   checked;

   vrf_top uut (
      .clk     (clk),
      .rstn    (rstn),
      .wreq_i  (wreq),
      .rreq_i  (rreq),
      .rresp_o (rresp)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   function automatic vrf_wreq_t make_write(input int addr, input logic [NBYTES-1:0] bwe,
                                            input logic [WIDTH-1:0] data);
      vrf_wreq_t w;
      w.wen   = 1'b1;
      w.waddr = AW'(addr);
      w.bwe   = bwe;
      w.wdata = data;
      return w;
   endfunction

   function automatic vrf_rreq_t make_read(input int addr);
      vrf_rreq_t r;
      r.ren   = 1'b1;
      r.raddr = AW'(addr);
      return r;
   endfunction

   // every address bit shows up in the word
   function automatic logic [WIDTH-1:0] fill_word(input int addr);
      logic [7:0] a8;
      a8 = 8'(addr);
      return {a8 ^ 8'h5a, ~a8, a8 * 8'd7, a8 ^ 8'hc3};
   endfunction

   function automatic void apply_writes(input vrf_wreq_t [W-1:0] wr);
      for (int p = 0; p < W; p++)
      begin
         if (wr[p].wen)
         begin
            for (int i = 0; i < NBYTES; i++)
            begin
               if (wr[p].bwe[i])
               begin
                  model_mem[wr[p].waddr][i*8 +: 8] = wr[p].wdata[i*8 +: 8];
               end
            end
         end
      end
   endfunction

   // writes of this cycle and the one before are not yet visible to a read
   function automatic bit recently_written(input logic [AW-1:0] addr,
                                           input vrf_wreq_t [W-1:0] wr);
      for (int p = 0; p < W; p++)
      begin
         if ((wr[p].wen && wr[p].waddr == addr) ||
             (wr_hist1[p].wen && wr_hist1[p].waddr == addr))
         begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   task automatic check_response(input exp_t e);
      for (int p = 0; p < R; p++)
      begin
         assert (rresp[p].rvalid === e.valid[p])
         else
            stop_on_error($sformatf("** Error: rresp[%0d].rvalid = %h, expected %h",
                                    p, rresp[p].rvalid, e.valid[p]));
         if (e.valid[p])
         begin
            assert (rresp[p].rdata === e.data[p])
            else
               stop_on_error($sformatf("** Error: rresp[%0d].rdata = %h, expected %h",
                                       p, rresp[p].rdata, e.data[p]));
            checked++;
         end
      end
   endtask

   // drive one cycle and check the responses to the reads of two cycles ago
   task automatic run_cycle(input vrf_wreq_t [W-1:0] wr, input vrf_rreq_t [R-1:0] rd,
                            input logic [R-1:0] fixed,
                            input logic [R-1:0][WIDTH-1:0] fixed_data);
      exp_t cur;
      @(posedge clk);
      wreq <= wr;
      rreq <= rd;
      // a read sees the writes driven two or more cycles before it
      apply_writes(wr_hist2);
      wr_hist2 = wr_hist1;
      wr_hist1 = wr;
      for (int p = 0; p < R; p++)
      begin
         cur.valid[p] = rd[p].ren;
         cur.data[p]  = fixed[p] ? fixed_data[p] : model_mem[rd[p].raddr];
      end
      @(negedge clk);
      check_response(exp_p2);
      exp_p2 = exp_p1;
      exp_p1 = cur;
   endtask

   task automatic add_row(input vrf_wreq_t w0, input vrf_wreq_t w1, input vrf_rreq_t r0,
                          input vrf_rreq_t r1, input vrf_rreq_t r2, input logic [R-1:0] fixed,
                          input logic [WIDTH-1:0] e0, input logic [WIDTH-1:0] e1,
                          input logic [WIDTH-1:0] e2);
      row_t row;
      row.wr    = {w1, w0};
      row.rd    = {r2, r1, r0};
      row.fixed = fixed;
      row.data  = {e2, e1, e0};
      if (row_count < TABLE_ROWS)
      begin
         table_rows[row_count] = row;
      end
      row_count++;
   endtask

   task automatic build_table();
      // full words from both ports read back on all read ports
      add_row(make_write(3, 4'hf, 32'h1111_2222), make_write(9, 4'hf, 32'h3333_4444),
              '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, make_read(3), make_read(3), make_read(9), 3'b111,
              32'h1111_2222, 32'h1111_2222, 32'h3333_4444);
      add_row('0, '0, make_read(9), make_read(9), make_read(3), 3'b111,
              32'h3333_4444, 32'h3333_4444, 32'h1111_2222);
      // byte merge across ports in separate cycles
      add_row(make_write(12, 4'hf, 32'hdead_beef), '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, make_write(12, 4'b0110, 32'h00c0_fe00), '0, '0, '0, 3'b000, '0, '0, '0);
      add_row(make_write(12, 4'b1000, 32'h7700_0000), '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, make_read(12), make_read(12), make_read(12), 3'b111,
              32'h77c0_feef, 32'h77c0_feef, 32'h77c0_feef);
      // disjoint bytes of one address in the same cycle
      add_row(make_write(20, 4'b0101, 32'h0012_0034), make_write(20, 4'b1010, 32'h5600_7800),
              '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, '0, make_read(20), '0, 3'b010, '0, 32'h5612_7834, '0);
      // back-to-back writes on alternating ports hit the forwarding path
      add_row(make_write(25, 4'hf, 32'ha0a0_0001), '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, make_write(25, 4'hf, 32'hb1b1_0002), '0, '0, '0, 3'b000, '0, '0, '0);
      add_row(make_write(25, 4'hf, 32'hc2c2_0003), '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, make_write(25, 4'hf, 32'hd3d3_0004), '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, make_read(25), make_read(25), make_read(25), 3'b111,
              32'hd3d3_0004, 32'hd3d3_0004, 32'hd3d3_0004);
      add_row(make_write(26, 4'hf, 32'h1234_5678), '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, make_write(26, 4'b1100, 32'habcd_0000), '0, '0, '0, 3'b000, '0, '0, '0);
      add_row(make_write(26, 4'b0011, 32'h0000_ef01), '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, make_read(26), make_read(26), make_read(26), 3'b111,
              32'habcd_ef01, 32'habcd_ef01, 32'habcd_ef01);
      // three ports, three different addresses
      add_row('0, '0, make_read(3), make_read(25), make_read(26), 3'b111,
              32'h1111_2222, 32'hd3d3_0004, 32'habcd_ef01);
      add_row('0, '0, make_read(12), make_read(20), make_read(9), 3'b111,
              32'h77c0_feef, 32'h5612_7834, 32'h3333_4444);
      add_row(make_write(3, 4'hf, 32'h0bad_f00d), '0, make_read(31), make_read(0),
              make_read(1), 3'b000, '0, '0, '0);
      add_row('0, '0, '0, '0, '0, 3'b000, '0, '0, '0);
      add_row('0, '0, make_read(3), make_read(3), make_read(31), 3'b011,
              32'h0bad_f00d, 32'h0bad_f00d, '0);
   endtask

   // both ports together write every address once
   task automatic fill_memory();
      vrf_wreq_t [W-1:0] wr;
      for (int i = 0; i < FILL_STEPS; i++)
      begin
         wr[0] = make_write(2*i, '1, fill_word(2*i));
         wr[1] = make_write(2*i + 1, '1, fill_word(2*i + 1));
         run_cycle(wr, '0, '0, '0);
      end
   endtask

   task automatic random_cycle();
      vrf_wreq_t [W-1:0] wr;
      vrf_rreq_t [R-1:0] rd;
      logic [AW-1:0]     addr;
      for (int p = 0; p < W; p++)
      begin
         wr[p].wen   = ($urandom_range(0, 1) != 0);
         wr[p].waddr = AW'($urandom_range(0, DEPTH - 1));
         wr[p].bwe   = NBYTES'($urandom());
         wr[p].wdata = WIDTH'($urandom());
         // drop the bytes an earlier port already writes here
         for (int q = 0; q < p; q++)
         begin
            if (wr[q].wen && wr[p].wen && wr[q].waddr == wr[p].waddr)
            begin
               wr[p].bwe = wr[p].bwe & ~wr[q].bwe;
            end
         end
      end
      for (int p = 0; p < R; p++)
      begin
         addr = AW'($urandom_range(0, DEPTH - 1));
         for (int t = 0; t < DEPTH && recently_written(addr, wr); t++)
         begin
            addr = addr + AW'(1);
         end
         rd[p].ren   = ($urandom_range(0, 3) != 0);
         rd[p].raddr = addr;
      end
      run_cycle(wr, rd, '0, '0);
   endtask

   initial
   begin
      void'($urandom(32'hbd87_2b85));
      rstn      = 1'b0;
      wreq      = '0;
      rreq      = '0;
      wr_hist1  = '0;
      wr_hist2  = '0;
      exp_p1    = '0;
      exp_p2    = '0;
      row_count = 0;
      checked   = 0;
      for (int a = 0; a < DEPTH; a++)
      begin
         model_mem[a] = '0;
      end
      build_table();
      assert (row_count == TABLE_ROWS)
      else
         stop_on_error("the stimulus table does not hold the expected number of rows");

      repeat (RESET_CYCLES) @(posedge clk);
      rstn <= 1'b1;

      // every rvalid stays low while idle after reset
      repeat (IDLE_STEPS) run_cycle('0, '0, '0, '0);

      fill_memory();
      for (int i = 0; i < TABLE_ROWS; i++)
      begin
         run_cycle(table_rows[i].wr, table_rows[i].rd, table_rows[i].fixed,
                   table_rows[i].data);
      end
      for (int i = 0; i < RAND_COUNT; i++)
      begin
         random_cycle();
      end
      repeat (DRAIN_STEPS) run_cycle('0, '0, '0, '0);

      $display("%0d read responses checked", checked);
      $display("Test completed successfully");
      $finish;
   end

   // watchdog
   initial
   begin
      #(RUN_CYCLES * CLK_PERIOD);
      stop_on_error("Timeout: the run did not finish within the watchdog limit");
   end

endmodule

// ==== vrf_top.f ====
+incdir+hdl
hdl/vrf_pkg.sv
hdl/sdp_bwe_bram.sv
hdl/vrf_write_encoder.sv
hdl/vrf_read_bank.sv
hdl/vrf_read_combiner.sv
hdl/vrf_top.sv
testbench/vrf_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = vrf_tb
FILELIST  = vrf_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "simulation FAILED, see $(LOG)"; \
	   exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
